// ==== Makefile ====
TOP = tb_top_mips

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'Test OK'

build:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module top_mips

clean:
	rm -rf obj_dir

// ==== logic/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
    // Inputs
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  mips_isa_pkg::word_t     i_instr,
    input  logic                    i_wb_valid,
    input  mips_isa_pkg::reg_addr_t i_wb_reg,
    input  mips_isa_pkg::word_t     i_wb_data,
    // ID/EX bundle
    id_ex_if.producer               o_idex
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    reg_addr_t dest;
    word_t     imm;
    word_t     rd_a;
    word_t     rd_b;
    alu_op_e   alu_op;
    logic      alu_src;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    word_t     regs [0:(1 << REG_ADDR_W)-1];

    assign opcode = opcode_e'(i_instr[31:26]);
    assign funct  = funct_e'(i_instr[5:0]);
    assign rs     = i_instr[25:21];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];
    assign imm    = {{(WORD_W-IMM_W){i_instr[IMM_W-1]}}, i_instr[IMM_W-1:0]};

    // --------------------
    // Control decode
    // --------------------
    always_comb begin
        alu_op    = ALU_ADD;
        alu_src   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        dest      = '0;
        case (opcode)
            OP_RTYPE: begin
                dest      = rd;
                reg_write = 1'b1;
                case (funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    // Unknown funct such as the all-zero NOP
                    default: reg_write = 1'b0;
                endcase
            end
            OP_ADDI, OP_ANDI, OP_ORI, OP_LW: begin
                dest      = rt;
                alu_src   = 1'b1;
                reg_write = 1'b1;
                mem_read  = (opcode == OP_LW);
                if (opcode == OP_ANDI) begin
                    alu_op = ALU_AND;
                end else if (opcode == OP_ORI) begin
                    alu_op = ALU_OR;
                end
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            default: ;
        endcase
    end

    // --------------------
    // Register file
    // --------------------
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        // Same-cycle write from write-back bypasses the array
        if (i_wb_valid && i_wb_reg == addr) begin
            return i_wb_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd_a = read_port(rs);
        rd_b = read_port(rt);
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            for (int i = 0; i < (1 << REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_valid) begin
            regs[i_wb_reg] <= i_wb_data;
        end
    end

    // ID/EX control
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_idex.rs        <= '0;
            o_idex.rt        <= '0;
            o_idex.dest      <= '0;
            o_idex.alu_op    <= ALU_ADD;
            o_idex.alu_src   <= 1'b0;
            o_idex.reg_write <= 1'b0;
            o_idex.mem_read  <= 1'b0;
            o_idex.mem_write <= 1'b0;
        end else begin
            o_idex.rs        <= rs;
            o_idex.rt        <= rt;
            o_idex.dest      <= dest;
            o_idex.alu_op    <= alu_op;
            o_idex.alu_src   <= alu_src;
            o_idex.reg_write <= reg_write;
            o_idex.mem_read  <= mem_read;
            o_idex.mem_write <= mem_write;
        end
    end

    // ID/EX operands
    always_ff @(posedge i_clk) begin
        o_idex.op_a <= rd_a;
        o_idex.op_b <= rd_b;
        o_idex.imm  <= imm;
    end

    // Memory stage never reports a write to the zero register
    a_no_wb_r0 : assert property (@(posedge i_clk) disable iff (!i_rst)
        i_wb_valid |-> (i_wb_reg != '0));

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
    // Inputs
    input  logic                    i_clk,
    input  logic                    i_rst,
    id_ex_if.consumer               i_idex,
    input  mips_pipe_pkg::fwd_sel_e i_fwd_a,
    input  mips_pipe_pkg::fwd_sel_e i_fwd_b,
    input  mips_isa_pkg::word_t     i_wb_data,
    // EX/MEM outputs
    output mips_isa_pkg::word_t     o_alu_result,
    output mips_isa_pkg::word_t     o_store_data,
    output mips_isa_pkg::reg_addr_t o_dest,
    output logic                    o_reg_write,
    output logic                    o_mem_read,
    output logic                    o_mem_write
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    word_t fwd_a_val;
    word_t fwd_b_val;
    word_t op_b;
    word_t alu_y;

    function automatic word_t pick(input fwd_sel_e sel, input word_t reg_val);
        case (sel)
            FWD_EX_MEM: return o_alu_result;
            FWD_MEM_WB: return i_wb_data;
            default:    return reg_val;
        endcase
    endfunction

    // --------------------
    // Operand muxes and ALU
    // --------------------
    always_comb begin
        fwd_a_val = pick(i_fwd_a, i_idex.op_a);
        fwd_b_val = pick(i_fwd_b, i_idex.op_b);
        op_b      = i_idex.alu_src ? i_idex.imm : fwd_b_val;
    end

    always_comb begin
        case (i_idex.alu_op)
            ALU_SUB: alu_y = fwd_a_val - op_b;
            ALU_AND: alu_y = fwd_a_val & op_b;
            ALU_OR:  alu_y = fwd_a_val | op_b;
            // Signed compare
            ALU_SLT: alu_y = {{(WORD_W-1){1'b0}}, $signed(fwd_a_val) < $signed(op_b)};
            default: alu_y = fwd_a_val + op_b;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_dest      <= '0;
            o_reg_write <= 1'b0;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
        end else begin
            o_dest      <= i_idex.dest;
            o_reg_write <= i_idex.reg_write;
            o_mem_read  <= i_idex.mem_read;
            o_mem_write <= i_idex.mem_write;
        end
    end

    always_ff @(posedge i_clk) begin
        o_alu_result <= alu_y;
        o_store_data <= fwd_b_val;
    end

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage (
    // Inputs
    input  logic                                  i_clk,
    input  logic                                  i_rst,
    input  logic                                  i_run,
    input  logic                                  i_imem_we,
    input  logic [mips_pipe_pkg::IMEM_ADDR_W-1:0] i_imem_addr,
    input  mips_isa_pkg::word_t                   i_imem_data,
    // Outputs
    output mips_isa_pkg::word_t                   o_instr,
    output logic [mips_pipe_pkg::IMEM_ADDR_W-1:0] o_pc
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    word_t                  imem [0:IMEM_DEPTH-1];
    logic [IMEM_ADDR_W-1:0] pc;

    // Program load port is open only while the core is halted
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            for (int i = 0; i < IMEM_DEPTH; i++) begin
                imem[i] <= '0;
            end
        end else if (i_imem_we && !i_run) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    // PC and IF/ID register
    always_ff @(posedge i_clk) begin
        if (!i_rst || !i_run) begin
            pc      <= '0;
            o_instr <= '0;
        end else begin
            pc      <= pc + 1'b1;
            o_instr <= imem[pc];
        end
    end

    assign o_pc = pc;

endmodule

// ==== logic/forwarding_unit.sv ====
`timescale 1ns/10ps

module forwarding_unit (
    // ID/EX bundle
    id_ex_if.consumer                i_idex,
    // Older instructions
    input  mips_isa_pkg::reg_addr_t  i_exmem_reg,
    input  logic                     i_exmem_reg_write,
    input  logic                     i_wb_valid,
    input  mips_isa_pkg::reg_addr_t  i_wb_reg,
    // Operand selects
    output mips_pipe_pkg::fwd_sel_e  o_fwd_a,
    output mips_pipe_pkg::fwd_sel_e  o_fwd_b
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    // EX/MEM is the younger result and wins over MEM/WB
    function automatic fwd_sel_e select(input reg_addr_t src);
        if (i_exmem_reg_write && i_exmem_reg != '0 && i_exmem_reg == src) begin
            return FWD_EX_MEM;
        end
        if (i_wb_valid && i_wb_reg == src) begin
            return FWD_MEM_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        o_fwd_a = select(i_idex.rs);
        o_fwd_b = select(i_idex.rt);
        // Legal selects and no forwarding into register 0
        if (!$isunknown({i_idex.rs, i_idex.rt, o_fwd_a, o_fwd_b})) begin
            a_fwd_legal : assert (o_fwd_a != 2'b11 && o_fwd_b != 2'b11 &&
                                  (i_idex.rs != '0 || o_fwd_a == FWD_REG) &&
                                  (i_idex.rt != '0 || o_fwd_b == FWD_REG));
        end
    end

endmodule

// ==== logic/id_ex_if.sv ====
`timescale 1ns/10ps

interface id_ex_if;
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    // Register indices
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dest;
    // Operands
    word_t     op_a;
    word_t     op_b;
    word_t     imm;
    // Control
    alu_op_e   alu_op;
    logic      alu_src;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;

    modport producer (output rs, rt, dest, op_a, op_b, imm,
                      output alu_op, alu_src, reg_write, mem_read, mem_write);
    modport consumer (input rs, rt, dest, op_a, op_b, imm,
                      input alu_op, alu_src, reg_write, mem_read, mem_write);
endinterface

// ==== logic/memory_stage.sv ====
`timescale 1ns/10ps

module memory_stage (
    // EX/MEM inputs
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  mips_isa_pkg::word_t     i_alu_result,
    input  mips_isa_pkg::word_t     i_store_data,
    input  mips_isa_pkg::reg_addr_t i_dest,
    input  logic                    i_reg_write,
    input  logic                    i_mem_read,
    input  logic                    i_mem_write,
    // Write-back bundle
    output logic                    o_wb_valid,
    output mips_isa_pkg::reg_addr_t o_wb_reg,
    output mips_isa_pkg::word_t     o_wb_data
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    word_t                  dmem [0:DMEM_DEPTH-1];
    logic [DMEM_ADDR_W-1:0] dmem_addr;
    logic                   load_q;
    word_t                  alu_q;
    word_t                  rdata_q;

    // Word addressing
    assign dmem_addr = i_alu_result[DMEM_ADDR_W+1:2];

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (i_mem_write) begin
            dmem[dmem_addr] <= i_store_data;
        end
    end

    // --------------------
    // MEM/WB register
    // --------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_wb_valid <= 1'b0;
            o_wb_reg   <= '0;
            load_q     <= 1'b0;
        end else begin
            o_wb_valid <= i_reg_write && (i_dest != '0);
            o_wb_reg   <= i_dest;
            load_q     <= i_mem_read;
        end
    end

    always_ff @(posedge i_clk) begin
        alu_q   <= i_alu_result;
        rdata_q <= dmem[dmem_addr];
    end

    assign o_wb_data = load_q ? rdata_q : alu_q;

    // Decode never issues a load and a store together
    a_mem_excl : assert property (@(posedge i_clk) disable iff (!i_rst)
        !(i_mem_read && i_mem_write));

endmodule

// ==== logic/mips_isa_pkg.sv ====
package mips_isa_pkg;

    // Datapath and field widths
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 16;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Primary opcode, bits 31 to 26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_e;

    // R-type function field, bits 5 to 0
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } funct_e;

endpackage

// ==== logic/mips_pipe_pkg.sv ====
package mips_pipe_pkg;

    // Memory sizes in words
    localparam int IMEM_DEPTH  = 64;
    localparam int IMEM_ADDR_W = 6;
    localparam int DMEM_DEPTH  = 16;
    localparam int DMEM_ADDR_W = 4;

    // ALU operation carried from decode to execute
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    // Source of an ALU operand
    typedef enum logic [1:0] {
        FWD_REG    = 2'b00,
        FWD_EX_MEM = 2'b01,
        FWD_MEM_WB = 2'b10
    } fwd_sel_e;

endpackage

// ==== logic/top_mips.sv ====
`timescale 1ns/10ps

module top_mips (
    // Inputs
    input  logic                                  i_clk,
    input  logic                                  i_rst,
    input  logic                                  i_run,
    input  logic                                  i_imem_we,
    input  logic [mips_pipe_pkg::IMEM_ADDR_W-1:0] i_imem_addr,
    input  mips_isa_pkg::word_t                   i_imem_data,
    // Outputs
    output logic                                  o_wb_valid,
    output mips_isa_pkg::reg_addr_t               o_wb_reg,
    output mips_isa_pkg::word_t                   o_wb_data
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    word_t     if_instr;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    word_t     ex_alu_result;
    word_t     ex_store_data;
    reg_addr_t ex_dest;
    logic      ex_reg_write;
    logic      ex_mem_read;
    logic      ex_mem_write;

    id_ex_if u_idex ();

    // --------------------
    // Stages
    // --------------------
    fetch_stage u_fetch (
        .i_clk       (i_clk        ),
        .i_rst       (i_rst        ),
        .i_run       (i_run        ),
        .i_imem_we   (i_imem_we    ),
        .i_imem_addr (i_imem_addr  ),
        .i_imem_data (i_imem_data  ),
        .o_instr     (if_instr     ),
        .o_pc        (             )
    );

    decode_stage u_decode (
        .i_clk      (i_clk      ),
        .i_rst      (i_rst      ),
        .i_instr    (if_instr   ),
        .i_wb_valid (o_wb_valid ),
        .i_wb_reg   (o_wb_reg   ),
        .i_wb_data  (o_wb_data  ),
        .o_idex     (u_idex     )
    );

    forwarding_unit u_fwd (
        .i_idex            (u_idex       ),
        .i_exmem_reg       (ex_dest      ),
        .i_exmem_reg_write (ex_reg_write ),
        .i_wb_valid        (o_wb_valid   ),
        .i_wb_reg          (o_wb_reg     ),
        .o_fwd_a           (fwd_a        ),
        .o_fwd_b           (fwd_b        )
    );

    execute_stage u_execute (
        .i_clk        (i_clk         ),
        .i_rst        (i_rst         ),
        .i_idex       (u_idex        ),
        .i_fwd_a      (fwd_a         ),
        .i_fwd_b      (fwd_b         ),
        .i_wb_data    (o_wb_data     ),
        .o_alu_result (ex_alu_result ),
        .o_store_data (ex_store_data ),
        .o_dest       (ex_dest       ),
        .o_reg_write  (ex_reg_write  ),
        .o_mem_read   (ex_mem_read   ),
        .o_mem_write  (ex_mem_write  )
    );

    memory_stage u_memory (
        .i_clk        (i_clk         ),
        .i_rst        (i_rst         ),
        .i_alu_result (ex_alu_result ),
        .i_store_data (ex_store_data ),
        .i_dest       (ex_dest       ),
        .i_reg_write  (ex_reg_write  ),
        .i_mem_read   (ex_mem_read   ),
        .i_mem_write  (ex_mem_write  ),
        .o_wb_valid   (o_wb_valid    ),
        .o_wb_reg     (o_wb_reg      ),
        .o_wb_data    (o_wb_data     )
    );

endmodule

// ==== verif/tb_top_mips.sv ====
`timescale 1ns/10ps

module tb_top_mips;
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    localparam int CHUNK_LEN   = 50;
    localparam int RANDOM_LEN  = 200;
    localparam int TEST_MARGIN = 40;
    localparam int DRAIN_MAX   = 10;
    localparam int QUIET_TAIL  = 6;

    logic                   i_clk = 1'b0;
    logic                   i_rst;
    logic                   i_run;
    logic                   i_imem_we;
    logic [IMEM_ADDR_W-1:0] i_imem_addr;
    word_t                  i_imem_data;
    logic                   o_wb_valid;
    reg_addr_t              o_wb_reg;
    word_t                  o_wb_data;

    word_t       prog [$];
    reg_addr_t   exp_reg [$];
    word_t       exp_data [$];
    string       test_name = "idle";
    int          exp_total;
    int          seen_cnt;
    int          test_errs;
    int          tests_run;
    int          tests_failed;
    int          total_errs;
    int          writes_checked;
    int          cycles;
    int          cycle_limit = 8;

    top_mips i_dut (
        .i_clk       (i_clk       ),
        .i_rst       (i_rst       ),
        .i_run       (i_run       ),
        .i_imem_we   (i_imem_we   ),
        .i_imem_addr (i_imem_addr ),
        .i_imem_data (i_imem_data ),
        .o_wb_valid  (o_wb_valid  ),
        .o_wb_reg    (o_wb_reg    ),
        .o_wb_data   (o_wb_data   )
    );

    always #5 i_clk = ~i_clk;

    // --------------------
    // Encoders and reference model
    // --------------------
    function automatic word_t enc_r(funct_e fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t enc_i(opcode_e op, reg_addr_t rt, reg_addr_t rs,
                                    logic [IMM_W-1:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Sequential ISA model with one write per instruction and none to r0
    function automatic void model_program();
        word_t     regs [0:31];
        word_t     mem [0:DMEM_DEPTH-1];
        word_t     instr;
        word_t     a;
        word_t     b;
        word_t     imm;
        word_t     res;
        word_t     addr;
        reg_addr_t dst;
        logic      wr;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            mem[i] = '0;
        end
        exp_reg.delete();
        exp_data.delete();
        foreach (prog[i]) begin
            instr = prog[i];
            a     = regs[instr[25:21]];
            b     = regs[instr[20:16]];
            imm   = {{16{instr[15]}}, instr[15:0]};
            addr  = a + imm;
            dst   = instr[20:16];
            wr    = 1'b1;
            res   = '0;
            case (instr[31:26])
                OP_RTYPE: begin
                    dst = instr[15:11];
                    case (instr[5:0])
                        FN_ADD:  res = a + b;
                        FN_SUB:  res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDI: res = a + imm;
                OP_ANDI: res = a & imm;
                OP_ORI:  res = a | imm;
                OP_LW:   res = mem[addr[5:2]];
                OP_SW: begin
                    wr = 1'b0;
                    mem[addr[5:2]] = b;
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0) begin
                regs[dst] = res;
                exp_reg.push_back(dst);
                exp_data.push_back(res);
            end
        end
    endfunction

    // --------------------
    // Programs
    // --------------------
    task automatic alu_ops_prog();
        prog.delete();
        prog.push_back(enc_i(OP_ADDI, 5'd1, 5'd0, 16'h0005));
        prog.push_back(enc_i(OP_ADDI, 5'd2, 5'd0, 16'hFFFD));
        prog.push_back(enc_i(OP_ADDI, 5'd3, 5'd0, 16'h70F0));
        prog.push_back(enc_i(OP_ORI, 5'd4, 5'd0, 16'h00FF));
        prog.push_back(enc_r(FN_ADD, 5'd5, 5'd1, 5'd2));
        prog.push_back(enc_r(FN_SUB, 5'd6, 5'd2, 5'd1));
        prog.push_back(enc_r(FN_AND, 5'd7, 5'd3, 5'd4));
        prog.push_back(enc_r(FN_OR, 5'd8, 5'd3, 5'd2));
        prog.push_back(enc_r(FN_SLT, 5'd9, 5'd2, 5'd1));
        prog.push_back(enc_r(FN_SLT, 5'd10, 5'd1, 5'd2));
        prog.push_back(enc_i(OP_ANDI, 5'd11, 5'd2, 16'h0FF0));
        prog.push_back(enc_i(OP_ORI, 5'd12, 5'd1, 16'h8000));
        prog.push_back(enc_i(OP_ADDI, 5'd13, 5'd2, 16'hFF9C));
    endtask

    // Each instruction consumes the one before it
    task automatic ex_mem_prog();
        prog.delete();
        prog.push_back(enc_i(OP_ADDI, 5'd1, 5'd0, 16'h0007));
        prog.push_back(enc_r(FN_ADD, 5'd2, 5'd1, 5'd1));
        prog.push_back(enc_r(FN_SUB, 5'd3, 5'd2, 5'd1));
        prog.push_back(enc_r(FN_OR, 5'd4, 5'd2, 5'd3));
        prog.push_back(enc_r(FN_SLT, 5'd5, 5'd4, 5'd2));
        prog.push_back(enc_i(OP_ADDI, 5'd6, 5'd5, 16'hFFF0));
        prog.push_back(enc_r(FN_SUB, 5'd7, 5'd0, 5'd6));
    endtask

    task automatic mem_wb_prog();
        prog.delete();
        prog.push_back(enc_i(OP_ADDI, 5'd1, 5'd0, 16'd12));
        prog.push_back(enc_i(OP_ADDI, 5'd2, 5'd0, 16'd99));
        prog.push_back(enc_r(FN_ADD, 5'd3, 5'd1, 5'd0));
        prog.push_back(enc_r(FN_OR, 5'd4, 5'd0, 5'd2));
        prog.push_back(enc_i(OP_SW, 5'd3, 5'd1, 16'd12));
        prog.push_back(enc_i(OP_LW, 5'd5, 5'd0, 16'd24));
        prog.push_back(enc_i(OP_ADDI, 5'd6, 5'd0, 16'd1));
        prog.push_back(enc_r(FN_ADD, 5'd7, 5'd5, 5'd6));
        prog.push_back(enc_i(OP_LW, 5'd8, 5'd0, 16'd24));
        prog.push_back(enc_r(FN_OR, 5'd9, 5'd0, 5'd0));
        prog.push_back(enc_r(FN_SUB, 5'd10, 5'd6, 5'd8));
    endtask

    task automatic load_store_prog();
        prog.delete();
        prog.push_back(enc_i(OP_ADDI, 5'd1, 5'd0, 16'h1234));
        prog.push_back(enc_i(OP_ADDI, 5'd2, 5'd0, 16'hFFFE));
        prog.push_back(enc_i(OP_ADDI, 5'd3, 5'd0, 16'h5A5A));
        prog.push_back(enc_i(OP_SW, 5'd1, 5'd0, 16'd0));
        prog.push_back(enc_i(OP_SW, 5'd2, 5'd0, 16'd4));
        prog.push_back(enc_i(OP_SW, 5'd3, 5'd0, 16'd60));
        prog.push_back(enc_i(OP_LW, 5'd4, 5'd0, 16'd0));
        prog.push_back(enc_i(OP_LW, 5'd5, 5'd0, 16'd4));
        prog.push_back(enc_i(OP_LW, 5'd6, 5'd0, 16'd60));
        prog.push_back(enc_i(OP_LW, 5'd7, 5'd0, 16'd8));
        prog.push_back(enc_i(OP_SW, 5'd2, 5'd0, 16'd8));
        prog.push_back(enc_i(OP_LW, 5'd8, 5'd0, 16'd8));
        prog.push_back(enc_i(OP_LW, 5'd9, 5'd0, 16'd0));
    endtask

    // Writes to r0 must vanish, and r0 must never be forwarded
    task automatic zero_reg_prog();
        prog.delete();
        prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd0, 16'd55));
        prog.push_back(enc_i(OP_ADDI, 5'd1, 5'd0, 16'd3));
        prog.push_back(enc_i(OP_ORI, 5'd0, 5'd1, 16'd7));
        prog.push_back(enc_i(OP_ADDI, 5'd2, 5'd0, 16'd9));
        prog.push_back(enc_r(FN_ADD, 5'd3, 5'd0, 5'd0));
        prog.push_back(enc_r(FN_ADD, 5'd0, 5'd1, 5'd2));
        prog.push_back(enc_r(FN_OR, 5'd4, 5'd0, 5'd1));
    endtask

    function automatic word_t random_instr();
        reg_addr_t        rs;
        reg_addr_t        rt;
        reg_addr_t        rd;
        logic [IMM_W-1:0] imm;
        logic [3:0]       widx;
        rs   = reg_addr_t'($urandom_range(7, 0));
        rt   = reg_addr_t'($urandom_range(7, 0));
        rd   = reg_addr_t'($urandom_range(7, 0));
        imm  = 16'($urandom);
        widx = 4'($urandom_range(15, 0));
        case ($urandom_range(9, 0))
            0:       return enc_r(FN_ADD, rd, rs, rt);
            1:       return enc_r(FN_SUB, rd, rs, rt);
            2:       return enc_r(FN_AND, rd, rs, rt);
            3:       return enc_r(FN_OR, rd, rs, rt);
            4:       return enc_r(FN_SLT, rd, rs, rt);
            5:       return enc_i(OP_ADDI, rt, rs, imm);
            6:       return enc_i(OP_ANDI, rt, rs, imm);
            7:       return enc_i(OP_ORI, rt, rs, imm);
            // r0 base keeps the address inside the 16 words
            8:       return enc_i(OP_LW, rt, 5'd0, {10'd0, widx, 2'b00});
            default: return enc_i(OP_SW, rt, 5'd0, {10'd0, widx, 2'b00});
        endcase
    endfunction

    // No instruction reads the register loaded right before it
    task automatic random_prog(input int n);
        word_t     cand;
        reg_addr_t load_dst;
        logic      uses;
        prog.delete();
        load_dst = '0;
        for (int i = 0; i < n; i++) begin
            do begin
                cand = random_instr();
                uses = (cand[25:21] == load_dst) ||
                       ((cand[31:26] == OP_RTYPE || cand[31:26] == OP_SW) &&
                        cand[20:16] == load_dst);
            end while (load_dst != '0 && uses);
            prog.push_back(cand);
            load_dst = (cand[31:26] == OP_LW) ? cand[20:16] : 5'd0;
        end
    endtask

    // --------------------
    // Checks
    // --------------------
    task automatic check_wb(input string name, input reg_addr_t exp_r, input word_t exp_d,
                            input reg_addr_t got_r, input word_t got_d);
        writes_checked++;
        if (got_r !== exp_r || got_d !== exp_d) begin
            $display("FAIL %s: expected r%0d = %h, actual r%0d = %h",
                     name, exp_r, exp_d, got_r, got_d);
            test_errs++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int seen);
        if (seen < expected) begin
            $display("ERROR %s: %0d register writes never appeared", name, expected - seen);
            test_errs++;
        end else if (seen > expected) begin
            $display("ERROR %s: %0d register writes that the program never made",
                     name, seen - expected);
            test_errs++;
        end
    endtask

    // Strobes are compared in order at the falling edge
    always @(negedge i_clk) begin
        if (i_rst === 1'b1 && o_wb_valid === 1'b1) begin
            seen_cnt++;
            if (exp_reg.size() == 0) begin
                $display("%s: unexpected write of %h to r%0d", test_name, o_wb_data, o_wb_reg);
            end else begin
                check_wb(test_name, exp_reg.pop_front(), exp_data.pop_front(),
                         o_wb_reg, o_wb_data);
            end
        end
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: simulation ran past %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    // --------------------
    // Drivers
    // --------------------
    task automatic apply_reset();
        i_rst     <= 1'b0;
        i_run     <= 1'b0;
        i_imem_we <= 1'b0;
        repeat (4) @(posedge i_clk);
        i_rst <= 1'b1;
    endtask

    task automatic load_chunk(input int base, input int n);
        for (int i = 0; i < n; i++) begin
            i_imem_we   <= 1'b1;
            i_imem_addr <= IMEM_ADDR_W'(i);
            i_imem_data <= prog[base + i];
            @(posedge i_clk);
        end
        i_imem_we <= 1'b0;
    endtask

    // Exactly n fetches, so the PC never wraps into stale words
    task automatic run_chunk(input int n);
        i_run <= 1'b1;
        repeat (n) @(posedge i_clk);
        i_run <= 1'b0;
    endtask

    task automatic run_test(input string name);
        int base;
        int n;
        int waited;
        cycle_limit += 2 * prog.size() + TEST_MARGIN;
        apply_reset();
        test_name = name;
        test_errs = 0;
        seen_cnt  = 0;
        model_program();
        exp_total = exp_reg.size();
        // Quiet window with the core halted
        repeat (3) @(posedge i_clk);
        base = 0;
        while (base < prog.size()) begin
            n = (prog.size() - base > CHUNK_LEN) ? CHUNK_LEN : prog.size() - base;
            load_chunk(base, n);
            run_chunk(n);
            base += n;
        end
        waited = 0;
        while (seen_cnt < exp_total && waited < DRAIN_MAX) begin
            @(posedge i_clk);
            waited++;
        end
        repeat (QUIET_TAIL) @(posedge i_clk);
        check_count(name, exp_total, seen_cnt);
        tests_run++;
        total_errs += test_errs;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("%-16s %s, %0d writes, %0d errors", name,
                 (test_errs == 0) ? "passed" : "failed", seen_cnt, test_errs);
    endtask

    initial begin
        i_rst       = 1'b0;
        i_run       = 1'b0;
        i_imem_we   = 1'b0;
        i_imem_addr = '0;
        i_imem_data = '0;
        void'($urandom(23));

        alu_ops_prog();
        run_test("alu_ops");
        ex_mem_prog();
        run_test("ex_mem_forward");
        mem_wb_prog();
        run_test("mem_wb_forward");
        load_store_prog();
        run_test("load_store");
        zero_reg_prog();
        run_test("zero_reg");
        random_prog(RANDOM_LEN);
        run_test("random_200");

        $display("Tests run %0d, failed %0d, writes checked %0d, errors %0d",
                 tests_run, tests_failed, writes_checked, total_errs);
        if (tests_failed == 0 && total_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/mips_isa_pkg.sv
logic/mips_pipe_pkg.sv
logic/id_ex_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/forwarding_unit.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/top_mips.sv
verif/tb_top_mips.sv
